// File: all.f
common/spiPkg.sv
common/memPkg.sv
source/inputConditioner.sv
source/shiftRegister.sv
source/spiController.sv
source/dataMemory.sv
source/spiMemory.sv
tests/clockGen.sv
tests/spiMemoryTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module spiMemoryTb -f all.f -o spiMemoryTb > build.log 2>&1 \
    || { cat build.log; echo "build failed, see build.log"; exit 1; }

./obj_dir/spiMemoryTb > sim.log 2>&1 \
    || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "PASS"

// File: tests/spiMemoryTb.sv
module spiMemoryTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int numTests = 18;
    localparam int halfPeriod = 10;
    localparam int frameLen = spiPkg::addrBits + 1 + spiPkg::dataBits;
    // each frame spends one extra bit time on cs setup and release
    localparam int cycleLimit = numTests * (frameLen + 1) * 2 * halfPeriod + 200;

    typedef enum logic [1:0] {
        opWrite,
        opRead,
        opAbortedWrite
    } opKind;

    logic clk;
    logic rstN;
    logic sclk;
    logic cs;
    logic mosi;
    logic miso;
    logic misoEn;

    string testName [numTests];
    opKind testOp [numTests];
    logic [spiPkg::addrBits-1:0] testAddr [numTests];
    logic [spiPkg::dataBits-1:0] testData [numTests];
    int testAbortBits [numTests];

    logic [spiPkg::dataBits-1:0] refMem [memPkg::memDepth];
    logic [31:0] rngState;
    int errorCount;
    int testErrors;
    int passCount;
    int failCount;
    int cycleCount;

    clockGen clocks (
        .clk  (clk),
        .rstN (rstN)
    );

    spiMemory dut0 (
        .clk    (clk),
        .rstN   (rstN),
        .sclk   (sclk),
        .cs     (cs),
        .mosi   (mosi),
        .miso   (miso),
        .misoEn (misoEn)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic setEntry(input int idx, input string name, input opKind op,
                            input logic [spiPkg::addrBits-1:0] addr,
                            input logic [spiPkg::dataBits-1:0] data, input int abortBits);
        testName[idx]      = name;
        testOp[idx]        = op;
        testAddr[idx]      = addr;
        testData[idx]      = data;
        testAbortBits[idx] = abortBits;
    endtask

    task automatic waitClocks(input int count);
        repeat (count) @(negedge clk);
    endtask

    task automatic checkValue(input string name, input string what,
                              input logic [7:0] expected, input logic [7:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s (%s): expected %02h, actual %02h",
                     name, what, expected, actual);
            testErrors++;
            errorCount++;
        end
    endtask

    // mode 0 master sets mosi while sclk is low and samples miso just before each rise
    task automatic runFrame(input string name, input logic readNotWrite,
                            input logic [spiPkg::addrBits-1:0] addr,
                            input logic [spiPkg::dataBits-1:0] data, input int dataCount,
                            output logic [spiPkg::dataBits-1:0] readByte);
        logic [frameLen-1:0] frameWord;
        logic sampled;
        logic expectEn;
        int i;
        frameWord = {addr, readNotWrite, data};
        readByte = '0;
        cs = 1'b0;
        for (i = 0; i < spiPkg::addrBits + 1 + dataCount; i++) begin
            mosi = frameWord[frameLen-1-i];
            waitClocks(halfPeriod);
            sampled = miso;
            // misoEn only during the data bits of a read
            expectEn = readNotWrite && (i > spiPkg::addrBits);
            checkValue(name, "misoEn", {7'b0, expectEn}, {7'b0, misoEn});
            if (i > spiPkg::addrBits) begin
                readByte = {readByte[spiPkg::dataBits-2:0], sampled};
            end
            sclk = 1'b1;
            waitClocks(halfPeriod);
            sclk = 1'b0;
        end
        waitClocks(halfPeriod);
        cs = 1'b1;
        waitClocks(halfPeriod);
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d clk cycles, controller in %s",
                 cycleLimit, dut0.controller.state.name());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int t;
        logic [spiPkg::dataBits-1:0] readByte;
        sclk = 1'b0;
        cs = 1'b1;
        mosi = 1'b0;
        errorCount = 0;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        rngState = 32'h7b8c9252;

        setEntry(0, "writeBasic", opWrite, 7'h15, 8'hb4, 0);
        setEntry(1, "readBasic", opRead, 7'h15, 8'h00, 0);
        rngState = xorshift32(rngState);
        setEntry(2, "writeRandA", opWrite, 7'h03, rngState[7:0], 0);
        rngState = xorshift32(rngState);
        setEntry(3, "writeRandB", opWrite, 7'h40, rngState[7:0], 0);
        rngState = xorshift32(rngState);
        setEntry(4, "writeRandC", opWrite, 7'h7f, rngState[7:0], 0);
        rngState = xorshift32(rngState);
        setEntry(5, "writeRandD", opWrite, 7'h2a, rngState[7:0], 0);
        // read back out of write order
        setEntry(6, "readRandC", opRead, 7'h7f, 8'h00, 0);
        setEntry(7, "readRandA", opRead, 7'h03, 8'h00, 0);
        setEntry(8, "readRandD", opRead, 7'h2a, 8'h00, 0);
        setEntry(9, "readRandB", opRead, 7'h40, 8'h00, 0);
        setEntry(10, "overwrite", opWrite, 7'h15, 8'h3c, 0);
        setEntry(11, "readOverwrite", opRead, 7'h15, 8'h00, 0);
        setEntry(12, "abortAfter3", opAbortedWrite, 7'h15, 8'hc3, 3);
        setEntry(13, "readAfterAbort3", opRead, 7'h15, 8'h00, 0);
        setEntry(14, "abortAfter7", opAbortedWrite, 7'h15, 8'hc3, 7);
        setEntry(15, "readAfterAbort7", opRead, 7'h15, 8'h00, 0);
        setEntry(16, "abortAfter0", opAbortedWrite, 7'h7f, 8'h00, 0);
        setEntry(17, "readAfterAbort0", opRead, 7'h7f, 8'h00, 0);

        wait (rstN === 1'b1);
        waitClocks(halfPeriod);
        checkValue("afterReset", "misoEn", 8'h00, {7'b0, misoEn});
        if (testErrors == 0) begin
            $display("afterReset: ok");
        end else begin
            $display("afterReset: %0d failed checks", testErrors);
        end

        for (t = 0; t < numTests; t++) begin
            testErrors = 0;
            case (testOp[t])
                opWrite: begin
                    runFrame(testName[t], 1'b0, testAddr[t], testData[t],
                             spiPkg::dataBits, readByte);
                    refMem[testAddr[t]] = testData[t];
                end
                opAbortedWrite: begin
                    // reference keeps the old byte
                    runFrame(testName[t], 1'b0, testAddr[t], testData[t],
                             testAbortBits[t], readByte);
                end
                opRead: begin
                    runFrame(testName[t], 1'b1, testAddr[t], 8'h00,
                             spiPkg::dataBits, readByte);
                    checkValue(testName[t], "read data", refMem[testAddr[t]], readByte);
                end
                default: begin
                    $display("test %s has an unknown operation", testName[t]);
                    testErrors++;
                    errorCount++;
                end
            endcase
            checkValue(testName[t], "misoEn between frames", 8'h00, {7'b0, misoEn});
            if (testErrors == 0) begin
                passCount++;
                $display("%s: ok", testName[t]);
            end else begin
                failCount++;
                $display("%s: %0d failed checks", testName[t], testErrors);
            end
        end

        $display("tests: %0d, passed: %0d, failed: %0d, failed checks: %0d",
                 numTests, passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tests/clockGen.sv
module clockGen (
    output logic clk,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for four clk cycles, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

// File: source/spiMemory.sv
module spiMemory (
    input  logic clk,
    input  logic rstN,
    input  logic sclk,
    input  logic cs,
    input  logic mosi,
    output logic miso,
    output logic misoEn
);

    logic sclkRise;
    logic sclkFall;
    logic csLevel;
    logic mosiLevel;
    logic addrWe;
    logic memWe;
    logic loadWe;
    logic [spiPkg::dataBits-1:0] shiftData;
    logic [spiPkg::dataBits-1:0] readData;

    inputConditioner sclkCond (
        .clk          (clk),
        .rstN         (rstN),
        .noisy        (sclk),
        .conditioned  (),
        .risingPulse  (sclkRise),
        .fallingPulse (sclkFall)
    );

    // cs idles high
    inputConditioner #(
        .resetLevel (1'b1)
    ) csCond (
        .clk          (clk),
        .rstN         (rstN),
        .noisy        (cs),
        .conditioned  (csLevel),
        .risingPulse  (),
        .fallingPulse ()
    );

    inputConditioner mosiCond (
        .clk          (clk),
        .rstN         (rstN),
        .noisy        (mosi),
        .conditioned  (mosiLevel),
        .risingPulse  (),
        .fallingPulse ()
    );

    spiController controller (
        .clk      (clk),
        .rstN     (rstN),
        .sclkRise (sclkRise),
        .csLevel  (csLevel),
        .rwBit    (shiftData[0]),
        .addrWe   (addrWe),
        .memWe    (memWe),
        .loadWe   (loadWe),
        .misoEn   (misoEn)
    );

    shiftRegister shifter (
        .clk         (clk),
        .rstN        (rstN),
        .shiftEn     (sclkRise),
        .serialIn    (mosiLevel),
        .loadEn      (loadWe),
        .parallelIn  (readData),
        .parallelOut (shiftData),
        .outEdge     (sclkFall),
        .serialOut   (miso)
    );

    // address sits above the rw flag after the eighth bit
    dataMemory memory (
        .clk       (clk),
        .rstN      (rstN),
        .addrWe    (addrWe),
        .addrIn    (shiftData[spiPkg::dataBits-1 -: spiPkg::addrBits]),
        .writeEn   (memWe),
        .writeData (shiftData),
        .readData  (readData)
    );

endmodule

// File: source/dataMemory.sv
module dataMemory (
    input  logic clk,
    input  logic rstN,
    input  logic addrWe,
    input  logic [spiPkg::addrBits-1:0] addrIn,
    input  logic writeEn,
    input  logic [spiPkg::dataBits-1:0] writeData,
    output logic [spiPkg::dataBits-1:0] readData
);

    logic [spiPkg::addrBits-1:0] addrReg;
    logic [spiPkg::dataBits-1:0] memArray [memPkg::memDepth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addrReg <= '0;
        end else if (addrWe) begin
            addrReg <= addrIn;
        end
    end

    // write and registered read both use the latched address
    always_ff @(posedge clk) begin
        if (writeEn) begin
            memArray[addrReg] <= writeData;
        end
        readData <= memArray[addrReg];
    end

endmodule

// File: source/spiController.sv
module spiController (
    input  logic clk,
    input  logic rstN,
    input  logic sclkRise,
    input  logic csLevel,
    input  logic rwBit,
    output logic addrWe,
    output logic memWe,
    output logic loadWe,
    output logic misoEn
);

    spiPkg::ctrlState state;
    logic [spiPkg::cntBits-1:0] bitCount;
    logic isRead;
    logic abort;

    // cs released mid-frame
    assign abort = csLevel && (state != spiPkg::idle);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= spiPkg::idle;
            bitCount <= '0;
        end else if (abort) begin
            state    <= spiPkg::idle;
            bitCount <= '0;
        end else begin
            unique case (state)
                spiPkg::idle: begin
                    if (sclkRise && !csLevel) begin
                        state    <= spiPkg::addressLoad;
                        bitCount <= '0;
                    end
                end
                spiPkg::addressLoad: begin
                    if (sclkRise) begin
                        if (bitCount == spiPkg::cntBits'(spiPkg::lastAddrCount)) begin
                            state    <= spiPkg::branch;
                            bitCount <= '0;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end
                spiPkg::branch: begin
                    // this rise shifts in the read/write flag
                    if (sclkRise) begin
                        state    <= spiPkg::dataLoad;
                        bitCount <= '0;
                    end
                end
                spiPkg::dataLoad: begin
                    if (sclkRise) begin
                        state    <= isRead ? spiPkg::readOut : spiPkg::writeIn;
                        bitCount <= spiPkg::cntBits'(1);
                    end else if (bitCount != '1) begin
                        // clk steps for address latch and memory read latency
                        bitCount <= bitCount + 1'b1;
                    end
                end
                spiPkg::readOut,
                spiPkg::writeIn: begin
                    if (sclkRise) begin
                        if (bitCount == spiPkg::cntBits'(spiPkg::lastDataCount)) begin
                            state    <= spiPkg::idle;
                            bitCount <= '0;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end
                default: begin
                    state    <= spiPkg::idle;
                    bitCount <= '0;
                end
            endcase
        end
    end

    // rw flag is in bit 0 during the first dataLoad cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            isRead <= 1'b0;
        end else if (abort || state == spiPkg::idle) begin
            isRead <= 1'b0;
        end else if (state == spiPkg::dataLoad && bitCount == '0) begin
            isRead <= rwBit;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addrWe <= 1'b0;
            loadWe <= 1'b0;
            memWe  <= 1'b0;
            misoEn <= 1'b0;
        end else begin
            addrWe <= !abort && state == spiPkg::branch && sclkRise;
            // read data is valid two clk after the address latch
            loadWe <= !abort && state == spiPkg::dataLoad && isRead
                      && bitCount == spiPkg::cntBits'(1);
            memWe  <= !abort && state == spiPkg::writeIn && sclkRise
                      && bitCount == spiPkg::cntBits'(spiPkg::lastDataCount);
            misoEn <= !abort && ((state == spiPkg::dataLoad && isRead)
                                 || state == spiPkg::readOut);
        end
    end

endmodule

// File: source/shiftRegister.sv
module shiftRegister (
    input  logic clk,
    input  logic rstN,
    input  logic shiftEn,
    input  logic serialIn,
    input  logic loadEn,
    input  logic [spiPkg::dataBits-1:0] parallelIn,
    output logic [spiPkg::dataBits-1:0] parallelOut,
    input  logic outEdge,
    output logic serialOut
);

    logic [spiPkg::dataBits-1:0] shiftReg;

    // msb first, so new bits enter at the bottom
    always_ff @(posedge clk) begin
        if (loadEn) begin
            shiftReg <= parallelIn;
        end else if (shiftEn) begin
            shiftReg <= {shiftReg[spiPkg::dataBits-2:0], serialIn};
        end
    end

    // miso only moves on falling sclk so the master samples a settled bit
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            serialOut <= 1'b0;
        end else if (outEdge) begin
            serialOut <= shiftReg[spiPkg::dataBits-1];
        end
    end

    assign parallelOut = shiftReg;

endmodule

// File: source/inputConditioner.sv
module inputConditioner #(
    parameter logic resetLevel = 1'b0
) (
    input  logic clk,
    input  logic rstN,
    input  logic noisy,
    output logic conditioned,
    output logic risingPulse,
    output logic fallingPulse
);

    logic syncFirst;
    logic syncSecond;
    logic prevLevel;
    logic [memPkg::debounceBits-1:0] stableCount;

    // two-flop synchronizer
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            syncFirst  <= resetLevel;
            syncSecond <= resetLevel;
        end else begin
            syncFirst  <= noisy;
            syncSecond <= syncFirst;
        end
    end

    // accept a new level only after it held for debounceWait cycles
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            conditioned <= resetLevel;
            stableCount <= '0;
        end else if (syncSecond == conditioned) begin
            stableCount <= '0;
        end else if (stableCount == memPkg::debounceBits'(memPkg::debounceWait - 1)) begin
            conditioned <= syncSecond;
            stableCount <= '0;
        end else begin
            stableCount <= stableCount + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            prevLevel <= resetLevel;
        end else begin
            prevLevel <= conditioned;
        end
    end

    // pulses line up with the first cycle of the new level
    assign risingPulse  = conditioned & ~prevLevel;
    assign fallingPulse = ~conditioned & prevLevel;

endmodule

// File: common/memPkg.sv
package memPkg;

    // one byte per address the frame can carry
    localparam int memDepth = 2 ** spiPkg::addrBits;

    // stable cycles needed before a synchronized pad level is accepted
    localparam int debounceWait = 3;
    localparam int debounceBits = 2;

endpackage

// File: common/spiPkg.sv
package spiPkg;

    // frame carries the address, the read/write flag, then one data byte
    localparam int addrBits = 7;
    localparam int dataBits = 8;

    // wide enough to index any bit of the data byte
    localparam int cntBits = $clog2(dataBits);

    // addressLoad sees six rises after the one that leaves idle
    localparam int lastAddrCount = addrBits - 2;

    // data phase counts its bits from the rise that leaves dataLoad
    localparam int lastDataCount = dataBits - 1;

    typedef enum logic [2:0] {
        idle,
        addressLoad,
        branch,
        dataLoad,
        readOut,
        writeIn
    } ctrlState;

endpackage
